// File: sources.f
hdl/eth_csr_pkg.sv
hdl/apb_csr_bridge.sv
hdl/eth_traffic_csr.sv
hdl/traffic_cfg_regs.sv
hdl/eth_traffic_csr_top.sv
dv/eth_traffic_csr_asserts.sv
dv/tb_eth_traffic_csr.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_eth_traffic_csr
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Verification passed

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status comes from the search for the pass message
run: $(BIN)
	./$(BIN) $(RUN_ARGS) | awk '{ print } index($$0, "$(PASS_MSG)") { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

// File: dv/tb_eth_traffic_csr.sv
`timescale 1ns/100ps

module tb_eth_traffic_csr
   import eth_csr_pkg::*;
();

localparam int     CLK_PERIOD    = 100;
localparam int     RST_CYCLES    = 4;
localparam int     PREADY_LIMIT  = 8;          // Cycles from access to pready
localparam int     IND_MAX_POLLS = 20;         // Busy polls per indirect access
localparam int     XFER_CYCLES   = 5;          // Idle + setup + 3 read access cycles
localparam int     NUM_DIRECT    = 100;        // Direct transfers, upper bound
localparam int     NUM_IND       = 64;         // Indirect accesses, upper bound
localparam longint TIMEOUT_NS    =
   longint'(NUM_DIRECT + NUM_IND * (IND_MAX_POLLS + 2)) * XFER_CYCLES * CLK_PERIOD
   + RST_CYCLES * CLK_PERIOD;
localparam logic [31:0] LFSR_SEED = 32'h97ef;

logic                   clk;
logic                   rst_n;
logic                   psel;
logic                   penable;
logic                   pwrite;
logic [CSR_ADDR_W-1:0]  paddr;
logic [CSR_DATA_W-1:0]  pwdata;
logic [CSR_STRB_W-1:0]  pstrb;
logic [CSR_DATA_W-1:0]  prdata;
logic                   pready;
logic [PORT_SEL_W-1:0]  port_sel;
logic                   swap_en;
logic [NUM_PORTS-1:0]   tx_enable;
logic [31:0]            lfsr_state;
logic [AVMM_DATA_W-1:0] cfg_model [NUM_PORTS][CFG_REGS_PER_PORT];  // Expected bank

eth_traffic_csr_top i_dut (
   .clk            (clk),
   .rst_n          (rst_n),
   .i_psel         (psel),
   .i_penable      (penable),
   .i_pwrite       (pwrite),
   .i_paddr        (paddr),
   .i_pwdata       (pwdata),
   .i_pstrb        (pstrb),
   .o_prdata       (prdata),
   .o_pready       (pready),
   .o_csr_port_sel (port_sel),
   .o_port_swap_en (swap_en),
   .o_tx_enable    (tx_enable)
);

initial begin
   clk = 1'b0;
   forever #(CLK_PERIOD / 2) clk = ~clk;
end

// ---------------------------------------------------------------------------
// Random data, x^32 + x^22 + x^2 + x + 1
// ---------------------------------------------------------------------------
function automatic logic [CSR_DATA_W-1:0] rand_bits(input int n);
   logic [CSR_DATA_W-1:0] v;
   logic                  fb;
   v = '0;
   for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v[i] = fb;                                // One step per bit
   end
   return v;
endfunction

task automatic check_equal(input logic [CSR_DATA_W-1:0] actual,
                           input logic [CSR_DATA_W-1:0] expected, input string msg);
   if (actual !== expected) begin
      $display("error: %0t ns: %s: got %h, expected %h", $time, msg, actual, expected);
      $display("Verification failed");
      $fatal(1, "Value mismatch");
   end
endtask

// ---------------------------------------------------------------------------
// APB driver
// ---------------------------------------------------------------------------
task automatic wait_pready();
   int n;
   n = 0;
   @(posedge clk);
   while (!pready) begin
      n++;
      if (n > PREADY_LIMIT) begin
         $display("APB transfer to address %h never got pready", paddr);
         $display("Verification failed");
         $fatal(1, "APB handshake stuck");
      end
      @(posedge clk);
   end
endtask

task automatic apb_write(input logic [CSR_ADDR_W-1:0] addr,
                         input logic [CSR_DATA_W-1:0] data, input logic [CSR_STRB_W-1:0] strb);
   @(posedge clk);
   psel    <= 1'b1;                             // Setup phase
   penable <= 1'b0;
   pwrite  <= 1'b1;
   paddr   <= addr;
   pwdata  <= data;
   pstrb   <= strb;
   @(posedge clk);
   penable <= 1'b1;
   wait_pready();
   psel    <= 1'b0;
   penable <= 1'b0;
endtask

task automatic apb_read(input logic [CSR_ADDR_W-1:0] addr, output logic [CSR_DATA_W-1:0] data);
   @(posedge clk);
   psel    <= 1'b1;
   penable <= 1'b0;
   pwrite  <= 1'b0;
   paddr   <= addr;
   pstrb   <= '0;
   @(posedge clk);
   penable <= 1'b1;
   wait_pready();
   data     = prdata;                           // Valid with pready
   psel    <= 1'b0;
   penable <= 1'b0;
endtask

// ---------------------------------------------------------------------------
// Indirect access helpers
// ---------------------------------------------------------------------------
task automatic wait_ind_idle(output logic [CSR_DATA_W-1:0] status);
   for (int i = 0; i < IND_MAX_POLLS; i++) begin
      apb_read(CSR_IND_RDATA, status);
      if (!status[IND_BUSY_BIT]) return;
   end
   $display("Indirect access still busy after %0d polls", IND_MAX_POLLS);
   $display("Verification failed");
   $fatal(1, "Indirect access stuck");
endtask

task automatic select_port(input int p);
   apb_write(CSR_PORT_CTRL, CSR_DATA_W'(p), '1);
endtask

task automatic ind_write(input int r, input logic [AVMM_DATA_W-1:0] data);
   logic [CSR_DATA_W-1:0] cmd;
   logic [CSR_DATA_W-1:0] status;
   cmd = CSR_DATA_W'(r);
   cmd[IND_CMD_WR_BIT] = 1'b1;
   apb_write(CSR_IND_WDATA, CSR_DATA_W'(data), '1);
   apb_write(CSR_IND_CMD, cmd, '1);
   wait_ind_idle(status);
endtask

task automatic ind_read(input int r, output logic [AVMM_DATA_W-1:0] data);
   logic [CSR_DATA_W-1:0] cmd;
   logic [CSR_DATA_W-1:0] status;
   cmd = CSR_DATA_W'(r);
   cmd[IND_CMD_RD_BIT] = 1'b1;
   apb_write(CSR_IND_CMD, cmd, '1);
   wait_ind_idle(status);
   data = status[AVMM_DATA_W-1:0];
endtask

task automatic check_cfg_bank();
   logic [AVMM_DATA_W-1:0] rd;
   for (int p = 0; p < NUM_PORTS; p++) begin
      select_port(p);
      for (int r = 0; r < CFG_REGS_PER_PORT; r++) begin
         ind_read(r, rd);
         check_equal(CSR_DATA_W'(rd), CSR_DATA_W'(cfg_model[p][r]),
                     $sformatf("port %0d reg %0d readback", p, r));
      end
   end
endtask

task automatic check_tx_enable();
   logic [NUM_PORTS-1:0] exp;
   for (int p = 0; p < NUM_PORTS; p++) exp[p] = cfg_model[p][0][0];   // Reg 0 bit 0
   check_equal(CSR_DATA_W'(tx_enable), CSR_DATA_W'(exp), "Tx enables");
endtask

// ---------------------------------------------------------------------------
// Directed tests
// ---------------------------------------------------------------------------
task automatic reset_state();
   logic [CSR_DATA_W-1:0] rd;
   apb_read(CSR_ID, rd);
   check_equal(rd, CSR_ID_VALUE, "ID register");
   apb_read(CSR_SCRATCH, rd);
   check_equal(rd, '0, "scratch after reset");
   apb_read(CSR_PORT_CTRL, rd);
   check_equal(rd, '0, "port control after reset");
   check_equal(CSR_DATA_W'(port_sel), '0, "port select after reset");
   check_equal(CSR_DATA_W'(swap_en), '0, "swap enable after reset");
   check_equal(CSR_DATA_W'(tx_enable), '0, "Tx enables after reset");
endtask

task automatic scratch_write_types();
   logic [CSR_DATA_W-1:0] wd;
   logic [CSR_DATA_W-1:0] rd;
   logic [CSR_DATA_W-1:0] exp;
   wd  = rand_bits(CSR_DATA_W);
   exp = wd;                                    // All strobes, full write
   apb_write(CSR_SCRATCH, wd, 8'hFF);
   apb_read(CSR_SCRATCH, rd);
   check_equal(rd, exp, "scratch full write");
   wd = rand_bits(CSR_DATA_W);
   exp[63:32] = wd[63:32];                      // Bit 2 set, upper half
   apb_write(CSR_SCRATCH | 12'h4, wd, 8'hF0);
   apb_read(CSR_SCRATCH, rd);
   check_equal(rd, exp, "scratch upper write");
   wd = rand_bits(CSR_DATA_W);
   exp[31:0] = wd[31:0];
   apb_write(CSR_SCRATCH, wd, 8'h0F);
   apb_read(CSR_SCRATCH, rd);
   check_equal(rd, exp, "scratch lower write");
   wd = rand_bits(CSR_DATA_W);
   exp[31:0] = wd[31:0];                        // Partial strobes still a half
   apb_write(CSR_SCRATCH, wd, 8'h3C);
   apb_read(CSR_SCRATCH, rd);
   check_equal(rd, exp, "scratch partial strobe write");
endtask

task automatic port_ctrl_update();
   logic [CSR_DATA_W-1:0] wd;
   logic [CSR_DATA_W-1:0] rd;
   logic [CSR_DATA_W-1:0] exp;
   for (int i = 0; i < 4; i++) begin
      wd  = rand_bits(CSR_DATA_W);
      exp = '0;
      exp[3:0] = wd[3:0];
      exp[8]   = wd[8];
      apb_write(CSR_PORT_CTRL, wd, '1);
      apb_read(CSR_PORT_CTRL, rd);
      check_equal(rd, exp, "port control readback");
      check_equal(CSR_DATA_W'(port_sel), CSR_DATA_W'(wd[3:0]), "port select output");
      check_equal(CSR_DATA_W'(swap_en), CSR_DATA_W'(wd[8]), "swap enable output");
   end
endtask

task automatic indirect_access();
   for (int p = 0; p < NUM_PORTS; p++) begin
      select_port(p);
      for (int r = 0; r < CFG_REGS_PER_PORT; r++) begin
         cfg_model[p][r] = AVMM_DATA_W'(rand_bits(AVMM_DATA_W));
         ind_write(r, cfg_model[p][r]);
      end
   end
   check_cfg_bank();
   check_tx_enable();
endtask

task automatic edge_cases();
   logic [CSR_DATA_W-1:0]  rd;
   logic [CSR_DATA_W-1:0]  cmd;
   logic [AVMM_DATA_W-1:0] ind_rd;
   apb_write(12'h0F8, rand_bits(CSR_DATA_W), '1);   // Unmapped, ignored
   apb_read(12'h0F8, rd);
   check_equal(rd, '0, "unmapped address");
   select_port(NUM_PORTS + 1);                      // Out of range port
   ind_write(0, AVMM_DATA_W'(rand_bits(AVMM_DATA_W)));
   ind_read(0, ind_rd);
   check_equal(CSR_DATA_W'(ind_rd), '0, "out of range port read");
   check_cfg_bank();
   check_tx_enable();
   // Second read command lands while the first is still busy
   select_port(1);
   cmd = CSR_DATA_W'(2);
   cmd[IND_CMD_RD_BIT] = 1'b1;
   apb_write(CSR_IND_CMD, cmd, '1);
   cmd = CSR_DATA_W'(3);
   cmd[IND_CMD_RD_BIT] = 1'b1;
   apb_write(CSR_IND_CMD, cmd, '1);
   wait_ind_idle(rd);
   check_equal(CSR_DATA_W'(rd[31:0]), CSR_DATA_W'(cfg_model[1][2]), "command while busy");
   ind_read(3, ind_rd);
   check_equal(CSR_DATA_W'(ind_rd), CSR_DATA_W'(cfg_model[1][3]), "read after drop");
endtask

// ---------------------------------------------------------------------------
// Sequence and watchdog
// ---------------------------------------------------------------------------
initial begin
   rst_n      = 1'b0;
   psel       = 1'b0;
   penable    = 1'b0;
   pwrite     = 1'b0;
   paddr      = '0;
   pwdata     = '0;
   pstrb      = '0;
   lfsr_state = LFSR_SEED;
   for (int p = 0; p < NUM_PORTS; p++) begin
      for (int r = 0; r < CFG_REGS_PER_PORT; r++) cfg_model[p][r] = '0;
   end
   repeat (RST_CYCLES) @(posedge clk);
   rst_n <= 1'b1;
   reset_state();
   scratch_write_types();
   port_ctrl_update();
   indirect_access();
   edge_cases();
   @(posedge clk);
   if (i_dut.u_asserts.err_cnt == 0) begin
      $display("Verification passed");
      $finish;
   end else begin
      $display("%0d assertion failures during the run", i_dut.u_asserts.err_cnt);
      $display("Verification failed");
      $fatal(1, "Assertion failures");
   end
end

initial begin
   #(TIMEOUT_NS);
   $display("Watchdog expired at %0t ns before the tests finished", $time);
   $display("Verification failed");
   $fatal(1, "Watchdog timeout");
end

endmodule

// File: dv/eth_traffic_csr_asserts.sv
`timescale 1ns/100ps

module eth_traffic_csr_asserts
   import eth_csr_pkg::*;
(
   input logic                    clk,
   input logic                    rst_n,
   input logic                    i_psel,
   input logic                    i_penable,
   input logic                    i_pready,
   input logic [AVMM_ADDR_W-1:0]  i_avmm_addr,
   input logic                    i_avmm_read,
   input logic                    i_avmm_write,
   input logic [AVMM_DATA_W-1:0]  i_avmm_writedata,
   input logic                    i_avmm_waitrequest
);

int err_cnt = 0;                                // Failures seen so far

// pready only inside an access phase
a_pready_access: assert property (@(posedge clk) disable iff (!rst_n)
   i_pready |-> (i_psel && i_penable))
   else begin
      err_cnt++;
      $error("pready without psel and penable");
   end

a_avmm_one_cmd: assert property (@(posedge clk) disable iff (!rst_n)
   !(i_avmm_read && i_avmm_write))
   else begin
      err_cnt++;
      $error("Avalon-MM read and write together");
   end

// Command frozen under waitrequest
a_avmm_stable: assert property (@(posedge clk) disable iff (!rst_n)
   i_avmm_waitrequest |=> ($stable(i_avmm_addr) && $stable(i_avmm_read)
                           && $stable(i_avmm_write) && $stable(i_avmm_writedata)))
   else begin
      err_cnt++;
      $error("Avalon-MM command changed under waitrequest");
   end

endmodule

bind eth_traffic_csr_top eth_traffic_csr_asserts u_asserts (
   .clk                (clk),
   .rst_n              (rst_n),
   .i_psel             (i_psel),
   .i_penable          (i_penable),
   .i_pready           (o_pready),
   .i_avmm_addr        (avmm_addr),
   .i_avmm_read        (avmm_read),
   .i_avmm_write       (avmm_write),
   .i_avmm_writedata   (avmm_writedata),
   .i_avmm_waitrequest (avmm_waitrequest)
);

// File: hdl/eth_traffic_csr_top.sv
`timescale 1ns/100ps

module eth_traffic_csr_top
   import eth_csr_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst_n,

   // APB
   input  logic                    i_psel,
   input  logic                    i_penable,
   input  logic                    i_pwrite,
   input  logic [CSR_ADDR_W-1:0]   i_paddr,
   input  logic [CSR_DATA_W-1:0]   i_pwdata,
   input  logic [CSR_STRB_W-1:0]   i_pstrb,
   output logic [CSR_DATA_W-1:0]   o_prdata,
   output logic                    o_pready,

   // Port controls
   output logic [PORT_SEL_W-1:0]   o_csr_port_sel,
   output logic                    o_port_swap_en,
   output logic [NUM_PORTS-1:0]    o_tx_enable
);

// Bridge to CSR block
logic                   csr_wr;
logic                   csr_rd;
logic [CSR_ADDR_W-1:0]  csr_addr;
csr_access_type_t       csr_wr_type;
logic [CSR_DATA_W-1:0]  csr_wr_data;
logic [CSR_DATA_W-1:0]  csr_rd_data;

// CSR block to config bank
logic [AVMM_ADDR_W-1:0] avmm_addr;
logic                   avmm_read;
logic                   avmm_write;
logic [AVMM_DATA_W-1:0] avmm_writedata;
logic [AVMM_DATA_W-1:0] avmm_readdata;
logic                   avmm_waitrequest;

apb_csr_bridge u_bridge (
   .clk            (clk),
   .rst_n          (rst_n),
   .i_psel         (i_psel),
   .i_penable      (i_penable),
   .i_pwrite       (i_pwrite),
   .i_paddr        (i_paddr),
   .i_pwdata       (i_pwdata),
   .i_pstrb        (i_pstrb),
   .o_prdata       (o_prdata),
   .o_pready       (o_pready),
   .o_csr_wr       (csr_wr),
   .o_csr_rd       (csr_rd),
   .o_csr_addr     (csr_addr),
   .o_csr_wr_type  (csr_wr_type),
   .o_csr_wr_data  (csr_wr_data),
   .i_csr_rd_data  (csr_rd_data)
);

eth_traffic_csr u_csr (
   .clk                (clk),
   .rst_n              (rst_n),
   .i_csr_wr           (csr_wr),
   .i_csr_rd           (csr_rd),
   .i_csr_addr         (csr_addr),
   .i_csr_wr_type      (csr_wr_type),
   .i_csr_wr_data      (csr_wr_data),
   .o_csr_rd_data      (csr_rd_data),
   .o_avmm_addr        (avmm_addr),
   .o_avmm_read        (avmm_read),
   .o_avmm_write       (avmm_write),
   .o_avmm_writedata   (avmm_writedata),
   .i_avmm_readdata    (avmm_readdata),
   .i_avmm_waitrequest (avmm_waitrequest),
   .o_csr_port_sel     (o_csr_port_sel),   // Also steers the bank
   .o_port_swap_en     (o_port_swap_en)
);

traffic_cfg_regs u_cfg (
   .clk                (clk),
   .rst_n              (rst_n),
   .i_port_sel         (o_csr_port_sel),
   .i_avmm_addr        (avmm_addr),
   .i_avmm_read        (avmm_read),
   .i_avmm_write       (avmm_write),
   .i_avmm_writedata   (avmm_writedata),
   .o_avmm_readdata    (avmm_readdata),
   .o_avmm_waitrequest (avmm_waitrequest),
   .o_tx_enable        (o_tx_enable)
);

endmodule

// File: hdl/traffic_cfg_regs.sv
`timescale 1ns/100ps

module traffic_cfg_regs
   import eth_csr_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst_n,

   input  logic [PORT_SEL_W-1:0]    i_port_sel,         // Selected port

   // Avalon-MM slave
   input  logic [AVMM_ADDR_W-1:0]   i_avmm_addr,
   input  logic                     i_avmm_read,
   input  logic                     i_avmm_write,
   input  logic [AVMM_DATA_W-1:0]   i_avmm_writedata,
   output logic [AVMM_DATA_W-1:0]   o_avmm_readdata,
   output logic                     o_avmm_waitrequest,

   output logic [NUM_PORTS-1:0]     o_tx_enable
);

// Per-port register file
logic [AVMM_DATA_W-1:0] cfg_mem [NUM_PORTS][CFG_REGS_PER_PORT];
logic [CFG_CNT_W-1:0]   wait_cnt;                       // Wait states so far
logic                   cmd_vld;
logic                   acc_done;
logic                   port_ok;
logic [PORT_IDX_W-1:0]  port_idx;
logic [CFG_IDX_W-1:0]   reg_idx;

assign cmd_vld  = i_avmm_read | i_avmm_write;
assign port_ok  = (i_port_sel < PORT_SEL_W'(NUM_PORTS)); // Out of range reads 0
assign port_idx = i_port_sel[PORT_IDX_W-1:0];
assign reg_idx  = i_avmm_addr[CFG_IDX_W-1:0];           // Low bits only

// ---------------------------------------------------------------------------
// Wait-state generation
// ---------------------------------------------------------------------------
assign o_avmm_waitrequest = cmd_vld & (wait_cnt != CFG_CNT_W'(CFG_WAIT_CYCLES));
assign acc_done           = cmd_vld & ~o_avmm_waitrequest;

always_ff @(posedge clk) begin
   if (!rst_n) begin
      wait_cnt <= '0;
   end else if (acc_done) begin
      wait_cnt <= '0;                                    // Rearm for next cmd
   end else if (cmd_vld) begin
      wait_cnt <= wait_cnt + 1'b1;
   end
end

// ---------------------------------------------------------------------------
// Register file
// ---------------------------------------------------------------------------
// Cleared on reset so all Tx enables start low
always_ff @(posedge clk) begin
   if (!rst_n) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
         for (int r = 0; r < CFG_REGS_PER_PORT; r++) begin
            cfg_mem[p][r] <= '0;
         end
      end
   end else if (acc_done & i_avmm_write & port_ok) begin
      cfg_mem[port_idx][reg_idx] <= i_avmm_writedata;
   end
end

// Read data valid in the cycle waitrequest drops
assign o_avmm_readdata = (i_avmm_read & port_ok) ? cfg_mem[port_idx][reg_idx] : '0;

// Tx enables
always_comb begin
   for (int p = 0; p < NUM_PORTS; p++) begin
      o_tx_enable[p] = cfg_mem[p][0][TX_EN_BIT];
   end
end

endmodule

// File: hdl/eth_traffic_csr.sv
`timescale 1ns/100ps

module eth_traffic_csr
   import eth_csr_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst_n,

   // CSR command from the bridge
   input  logic                     i_csr_wr,
   input  logic                     i_csr_rd,
   input  logic [CSR_ADDR_W-1:0]    i_csr_addr,
   input  csr_access_type_t         i_csr_wr_type,
   input  logic [CSR_DATA_W-1:0]    i_csr_wr_data,
   output logic [CSR_DATA_W-1:0]    o_csr_rd_data,

   // Avalon-MM master to the config bank
   output logic [AVMM_ADDR_W-1:0]   o_avmm_addr,
   output logic                     o_avmm_read,
   output logic                     o_avmm_write,
   output logic [AVMM_DATA_W-1:0]   o_avmm_writedata,
   input  logic [AVMM_DATA_W-1:0]   i_avmm_readdata,
   input  logic                     i_avmm_waitrequest,

   // Port controls
   output logic [PORT_SEL_W-1:0]    o_csr_port_sel,
   output logic                     o_port_swap_en   // Tx port swap
);

// Merge a write into the current register image
function automatic logic [CSR_DATA_W-1:0] merge_wr(
   input logic [CSR_DATA_W-1:0] cur,
   input logic [CSR_DATA_W-1:0] wdata,
   input csr_access_type_t      wtype
);
   case (wtype)
      UPPER32: merge_wr = {wdata[CSR_DATA_W-1:CSR_HALF_W], cur[CSR_HALF_W-1:0]};
      LOWER32: merge_wr = {cur[CSR_DATA_W-1:CSR_HALF_W], wdata[CSR_HALF_W-1:0]};
      default: merge_wr = wdata;
   endcase
endfunction

logic [CSR_ADDR_W-1:0]   reg_addr;                 // 8-byte aligned
logic [CSR_DATA_W-1:0]   scratch;
logic [AVMM_ADDR_W-1:0]  ind_addr;
logic [AVMM_DATA_W-1:0]  ind_wdata;
logic [AVMM_DATA_W-1:0]  ind_rdata;                // Last indirect read
ind_state_t              ind_state;
logic                    busy;
logic [CSR_DATA_W-1:0]   ctrl_img;
logic [CSR_DATA_W-1:0]   cmd_img;
logic [CSR_DATA_W-1:0]   rdata_img;
logic [CSR_DATA_W-1:0]   ctrl_new;
logic [CSR_DATA_W-1:0]   cmd_new;
logic [CSR_DATA_W-1:0]   wdata_new;
logic                    wr_cmd;
logic                    ind_start;

assign reg_addr = {i_csr_addr[CSR_ADDR_W-1:3], 3'b000};
assign busy     = (ind_state == IND_BUSY);

// Register images as seen on the CSR bus
always_comb begin
   ctrl_img = '0;
   ctrl_img[PORT_SEL_W-1:0] = o_csr_port_sel;
   ctrl_img[PORT_SWAP_BIT]  = o_port_swap_en;

   cmd_img = '0;
   cmd_img[AVMM_ADDR_W-1:0] = ind_addr;
   cmd_img[IND_CMD_WR_BIT]  = o_avmm_write;       // Pending request bits
   cmd_img[IND_CMD_RD_BIT]  = o_avmm_read;

   rdata_img = '0;
   rdata_img[AVMM_DATA_W-1:0] = ind_rdata;
   rdata_img[IND_BUSY_BIT]    = busy;
end

assign ctrl_new  = merge_wr(ctrl_img, i_csr_wr_data, i_csr_wr_type);
assign cmd_new   = merge_wr(cmd_img, i_csr_wr_data, i_csr_wr_type);
assign wdata_new = merge_wr({{CSR_HALF_W{1'b0}}, ind_wdata}, i_csr_wr_data, i_csr_wr_type);
assign wr_cmd    = i_csr_wr & (reg_addr == CSR_IND_CMD);
// Dropped while busy
assign ind_start = wr_cmd & ~busy & (cmd_new[IND_CMD_WR_BIT] | cmd_new[IND_CMD_RD_BIT]);

// ---------------------------------------------------------------------------
// CSR registers
// ---------------------------------------------------------------------------
always_ff @(posedge clk) begin
   if (!rst_n) begin
      scratch        <= '0;
      o_csr_port_sel <= '0;
      o_port_swap_en <= 1'b0;
      ind_addr       <= '0;
      ind_wdata      <= '0;
   end else if (i_csr_wr) begin
      case (reg_addr)
         CSR_SCRATCH: scratch <= merge_wr(scratch, i_csr_wr_data, i_csr_wr_type);
         CSR_PORT_CTRL: begin
            o_csr_port_sel <= ctrl_new[PORT_SEL_W-1:0];
            o_port_swap_en <= ctrl_new[PORT_SWAP_BIT];
         end
         CSR_IND_CMD: begin
            if (!busy) ind_addr <= cmd_new[AVMM_ADDR_W-1:0];  // Held under access
         end
         CSR_IND_WDATA: begin
            ind_wdata <= wdata_new[AVMM_DATA_W-1:0];    // Only the low half exists
         end
         default: ;                                 // Unmapped, ignored
      endcase
   end
end

// Registered read mux, data follows the rd pulse by one cycle
always_ff @(posedge clk) begin
   if (i_csr_rd) begin
      case (reg_addr)
         CSR_ID:        o_csr_rd_data <= CSR_ID_VALUE;
         CSR_SCRATCH:   o_csr_rd_data <= scratch;
         CSR_PORT_CTRL: o_csr_rd_data <= ctrl_img;
         CSR_IND_CMD:   o_csr_rd_data <= cmd_img;
         CSR_IND_WDATA: o_csr_rd_data <= {{CSR_HALF_W{1'b0}}, ind_wdata};
         CSR_IND_RDATA: o_csr_rd_data <= rdata_img;
         default:       o_csr_rd_data <= '0;
      endcase
   end
end

// ---------------------------------------------------------------------------
// Indirect Avalon-MM master
// ---------------------------------------------------------------------------
always_ff @(posedge clk) begin
   if (!rst_n) begin
      ind_state    <= IND_IDLE;
      o_avmm_read  <= 1'b0;
      o_avmm_write <= 1'b0;
      ind_rdata    <= '0;
   end else begin
      case (ind_state)
         IND_IDLE: begin
            if (ind_start) begin
               ind_state    <= IND_BUSY;
               o_avmm_write <= cmd_new[IND_CMD_WR_BIT];
               o_avmm_read  <= cmd_new[IND_CMD_RD_BIT] & ~cmd_new[IND_CMD_WR_BIT];
            end
         end
         IND_BUSY: begin
            if (!i_avmm_waitrequest) begin            // Access ends this cycle
               ind_state    <= IND_IDLE;
               o_avmm_read  <= 1'b0;
               o_avmm_write <= 1'b0;
               if (o_avmm_read) ind_rdata <= i_avmm_readdata;
            end
         end
         default: ind_state <= IND_IDLE;
      endcase
   end
end

// Write data frozen at launch
always_ff @(posedge clk) begin
   if (ind_start) o_avmm_writedata <= ind_wdata;
end

assign o_avmm_addr = ind_addr;

endmodule

// File: hdl/apb_csr_bridge.sv
`timescale 1ns/100ps

module apb_csr_bridge
   import eth_csr_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst_n,

   // APB completer side
   input  logic                    i_psel,
   input  logic                    i_penable,
   input  logic                    i_pwrite,
   input  logic [CSR_ADDR_W-1:0]   i_paddr,
   input  logic [CSR_DATA_W-1:0]   i_pwdata,
   input  logic [CSR_STRB_W-1:0]   i_pstrb,
   output logic [CSR_DATA_W-1:0]   o_prdata,
   output logic                    o_pready,

   // CSR command side
   output logic                    o_csr_wr,       // One-cycle write pulse
   output logic                    o_csr_rd,       // One-cycle read pulse
   output logic [CSR_ADDR_W-1:0]   o_csr_addr,
   output csr_access_type_t        o_csr_wr_type,
   output logic [CSR_DATA_W-1:0]   o_csr_wr_data,
   input  logic [CSR_DATA_W-1:0]   i_csr_rd_data   // Valid cycle after o_csr_rd
);

apb_state_t             state;
logic [APB_RD_CNT_W-1:0] rd_cnt;                   // Read access cycles seen
logic                   setup_phase;
logic                   access_phase;
logic                   wr_fire;
logic                   rd_fire;
csr_access_type_t       wr_type;

assign setup_phase  = i_psel & ~i_penable;
assign access_phase = i_psel & i_penable;

// Write fires in its only access cycle, read in its first
assign wr_fire = (state == DONE) & access_phase & i_pwrite;
assign rd_fire = (state == WAIT_RD) & access_phase & (rd_cnt == '0);

// Half or full write from strobes, bit 2 picks the half
assign wr_type = (&i_pstrb) ? FULL64
               : i_paddr[2] ? UPPER32
               : LOWER32;

// ---------------------------------------------------------------------------
// Transfer FSM
// ---------------------------------------------------------------------------
always_ff @(posedge clk) begin
   if (!rst_n) begin
      state    <= IDLE;
      o_pready <= 1'b0;
      rd_cnt   <= '0;
   end else begin
      case (state)
         IDLE: begin
            rd_cnt <= '0;
            if (setup_phase) begin
               state    <= i_pwrite ? DONE : WAIT_RD;
               o_pready <= i_pwrite;           // Write done in 1st access cycle
            end
         end
         WAIT_RD: begin
            if (access_phase) begin
               rd_cnt <= rd_cnt + 1'b1;
               // One cycle early so pready lands with the read data
               if (rd_cnt == APB_RD_CNT_W'(APB_RD_ACCESS - 2)) begin
                  state    <= DONE;
                  o_pready <= 1'b1;
               end
            end
         end
         DONE: begin                            // pready is high here
            state    <= IDLE;
            o_pready <= 1'b0;
         end
         default: state <= IDLE;
      endcase
   end
end

// Command pulses, one per transfer
always_ff @(posedge clk) begin
   if (!rst_n) begin
      o_csr_wr <= 1'b0;
      o_csr_rd <= 1'b0;
   end else begin
      o_csr_wr <= wr_fire;
      o_csr_rd <= rd_fire;
   end
end

// Command payload, captured with the pulse
always_ff @(posedge clk) begin
   if (wr_fire | rd_fire) begin
      o_csr_addr    <= i_paddr;
      o_csr_wr_type <= wr_type;
      o_csr_wr_data <= i_pwdata;
   end
end

// CSR read mux is registered, so data is there in the pready cycle
assign o_prdata = (o_pready & ~i_pwrite) ? i_csr_rd_data : '0;

endmodule

// File: hdl/eth_csr_pkg.sv
package eth_csr_pkg;

   // ------------------------------------------------------------------------
   // Widths
   // ------------------------------------------------------------------------
   localparam int CSR_DATA_W  = 64;                 // APB and CSR data
   localparam int CSR_STRB_W  = CSR_DATA_W / 8;     // One strobe per byte
   localparam int CSR_HALF_W  = CSR_DATA_W / 2;     // Upper/lower half split
   localparam int CSR_ADDR_W  = 12;                 // APB byte address
   localparam int AVMM_ADDR_W = 16;                 // Avalon-MM word address
   localparam int AVMM_DATA_W = 32;

   // APB read timing
   localparam int APB_RD_ACCESS = 3;                // pready in 3rd access cycle
   localparam int APB_RD_CNT_W  = $clog2(APB_RD_ACCESS);

   // Configuration bank geometry
   localparam int NUM_PORTS         = 4;
   localparam int PORT_SEL_W        = 4;
   localparam int PORT_IDX_W        = $clog2(NUM_PORTS);
   localparam int CFG_REGS_PER_PORT = 4;
   localparam int CFG_IDX_W         = $clog2(CFG_REGS_PER_PORT);
   localparam int CFG_WAIT_CYCLES   = 2;            // waitrequest cycles per access
   localparam int CFG_CNT_W         = $clog2(CFG_WAIT_CYCLES + 1);
   localparam int TX_EN_BIT         = 0;            // Bit 0 of register 0

   // ------------------------------------------------------------------------
   // CSR map, byte addresses of 64-bit registers
   // ------------------------------------------------------------------------
   localparam logic [CSR_DATA_W-1:0] CSR_ID_VALUE = 64'h4554_4847_0001_0000;

   localparam logic [CSR_ADDR_W-1:0] CSR_ID        = 12'h000;
   localparam logic [CSR_ADDR_W-1:0] CSR_SCRATCH   = 12'h008;
   localparam logic [CSR_ADDR_W-1:0] CSR_PORT_CTRL = 12'h010;
   localparam logic [CSR_ADDR_W-1:0] CSR_IND_CMD   = 12'h018;
   localparam logic [CSR_ADDR_W-1:0] CSR_IND_WDATA = 12'h020;
   localparam logic [CSR_ADDR_W-1:0] CSR_IND_RDATA = 12'h028;

   // Field positions
   localparam int PORT_SWAP_BIT  = 8;               // PORT_CTRL swap enable
   localparam int IND_CMD_WR_BIT = 32;              // IND_CMD write request
   localparam int IND_CMD_RD_BIT = 33;              // IND_CMD read request
   localparam int IND_BUSY_BIT   = 32;              // IND_RDATA busy flag

   // ------------------------------------------------------------------------
   // Enums
   // ------------------------------------------------------------------------
   typedef enum logic [1:0] {FULL64, UPPER32, LOWER32} csr_access_type_t;

   typedef enum logic [1:0] {IDLE, WAIT_RD, DONE} apb_state_t;

   typedef enum logic {IND_IDLE, IND_BUSY} ind_state_t;

endpackage
